/* Makefile */
TOP = score_hud_tb
OBJ = obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): files.f $(wildcard source/*.sv source/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir $(OBJ)

run: $(OBJ)/V$(TOP)
	-./$(OBJ)/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log || ! grep -q "Result: PASSED" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log

/* files.f */
+incdir+source
source/hud_event_pkg.sv
source/hud_draw_pkg.sv
source/blit_if.sv
source/hud_event_decode.sv
source/bcd_converter.sv
source/glyph_ram.sv
source/glyph_blitter.sv
source/fb_write_port.sv
source/score_hud.sv
tb/score_hud_properties.sv
tb/score_hud_tb.sv

/* source/bcd_converter.sv */
`timescale 1ns/1ps

module bcd_converter
#(
    parameter int VALUE_WIDTH = 20
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  logic [VALUE_WIDTH-1:0]     value,
    output hud_draw_pkg::digit_vec_t   digits,
    output logic                       done
);
    localparam int COUNT_W = $clog2(VALUE_WIDTH + 1);
    localparam int BCD_W   = $bits(hud_draw_pkg::digit_vec_t);

    logic [VALUE_WIDTH-1:0] bin_q;
    logic [COUNT_W-1:0]     count_q;
    logic [BCD_W-1:0]       adjusted;

    // add 3 to every digit of 5 or more before the shift.
    always_comb
    begin
        adjusted = digits;
        for (int i = 0; i < BCD_W / 4; i++)
        begin
            if (adjusted[4*i +: 4] >= 4'd5)
                adjusted[4*i +: 4] = adjusted[4*i +: 4] + 4'd3;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            count_q <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= (count_q == COUNT_W'(1));   // last shift happens now.
            if (start)
                count_q <= COUNT_W'(VALUE_WIDTH);
            else if (count_q != '0)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            bin_q  <= value;
            digits <= '0;
        end
        else if (count_q != '0)
        begin
            digits <= {adjusted[BCD_W-2:0], bin_q[VALUE_WIDTH-1]};
            bin_q  <= bin_q << 1;
        end
    end
endmodule

/* source/blit_if.sv */
`timescale 1ns/1ps

interface blit_if
(
    input logic clk,
    input logic reset
);
    logic                     push;
    hud_draw_pkg::blit_word_t word;
    logic                     credit_return;   // one pulse per word popped.

    modport sender
    (
        input  clk,
        input  reset,
        output push,
        output word,
        input  credit_return
    );

    modport receiver
    (
        input  clk,
        input  reset,
        input  push,
        input  word,
        output credit_return
    );
endinterface

/* source/fb_write_port.sv */
`timescale 1ns/1ps
`include "hud_cfg.svh"

module fb_write_port
(
    input  logic         clk,
    input  logic         reset,
    input  logic         mem_credit,
    blit_if.receiver     blit,
    output logic         mem_wr,
    output logic [21:0]  mem_addr,
    output logic [127:0] mem_data,
    output logic [15:0]  mem_be,
    output logic         done
);
    localparam int DEPTH = `HUD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int MCR_W = $clog2(`HUD_MEM_CREDITS + 1);

    hud_draw_pkg::blit_word_t fifo_q [DEPTH];
    hud_draw_pkg::blit_word_t head;
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count_q;
    logic [MCR_W-1:0]         mem_credit_count;
    logic                     fifo_empty;
    logic                     pop;
    logic                     fifo_wr;
    logic                     fifo_rd;
    logic                     credit_return_q;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // an empty fifo passes the incoming word straight through.
    assign fifo_empty = (count_q == '0);
    assign head    = fifo_empty ? blit.word : fifo_q[rd_ptr];
    assign pop     = (!fifo_empty || blit.push) && (mem_credit_count != '0);
    assign fifo_rd = pop && !fifo_empty;
    assign fifo_wr = blit.push && !(fifo_empty && pop);

    assign blit.credit_return = credit_return_q;

    always_ff @(posedge clk)
    begin
        if (fifo_wr)
            fifo_q[wr_ptr] <= blit.word;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            count_q          <= '0;
            mem_credit_count <= MCR_W'(`HUD_MEM_CREDITS);
            mem_wr           <= 1'b0;
            done             <= 1'b0;
            credit_return_q  <= 1'b0;
        end
        else
        begin
            if (fifo_wr)
                wr_ptr <= ptr_next(wr_ptr);
            if (fifo_rd)
                rd_ptr <= ptr_next(rd_ptr);
            count_q          <= count_q + CNT_W'(fifo_wr) - CNT_W'(fifo_rd);
            mem_credit_count <= mem_credit_count - MCR_W'(pop) + MCR_W'(mem_credit);
            mem_wr           <= pop;
            done             <= pop && head.last;
            credit_return_q  <= pop;    // lines up with mem_wr.
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            mem_addr <= head.addr;
            mem_data <= head.data;
        end
    end

    // transparent pixels are not written.
    always_comb
    begin
        for (int i = 0; i < 16; i++)
            mem_be[i] = (mem_data[8*i +: 8] != `HUD_TRANSPARENT);
    end
endmodule

/* source/glyph_blitter.sv */
`timescale 1ns/1ps
`include "hud_cfg.svh"

module glyph_blitter
(
    input  logic         clk,
    input  logic         reset,
    input  logic         draw_start,
    input  logic [19:0]  score_value,
    input  logic [9:0]   combo_value,
    input  logic         buf_sel,
    input  logic [127:0] glyph_data,
    output logic [6:0]   glyph_addr,
    output logic         draw_busy,
    blit_if.sender       blit
);
    localparam int ROW_W    = $clog2(`HUD_GLYPH_ROWS);
    localparam int CREDIT_W = $clog2(`HUD_FIFO_DEPTH + 1);
    localparam int SUM_W    = CREDIT_W + 1;

    typedef enum logic [2:0]
    {
        IDLE,
        CONVERT,
        READ,
        PUSH,
        DRAIN
    } state_e;

    state_e                   state;
    hud_draw_pkg::digit_vec_t score_digits;
    hud_draw_pkg::digit_vec_t combo_digits;
    logic                     score_done;
    logic                     combo_done;
    logic                     score_ready;
    logic                     combo_ready;
    logic                     conv_start;
    logic [CREDIT_W-1:0]      credit_count;
    logic [SUM_W-1:0]         credit_after_return;
    logic                     spend;
    logic                     drain_complete;
    logic                     combo_section;
    logic                     combo_nonzero;
    logic [2:0]               pos;
    logic [2:0]               last_pos;
    logic [ROW_W-1:0]         row;
    logic [3:0]               cur_digit;
    logic                     final_word;
    logic [21:0]              base_addr;
    logic [21:0]              origin;
    logic [21:0]              word_addr;
    logic                     push_q;
    hud_draw_pkg::blit_word_t word_q;

    assign conv_start = (state == IDLE) && draw_start;

    bcd_converter #(.VALUE_WIDTH(20)) score_bcd_i
    (
        .clk    (clk),
        .reset  (reset),
        .start  (conv_start),
        .value  (score_value),
        .digits (score_digits),
        .done   (score_done)
    );

    bcd_converter #(.VALUE_WIDTH(10)) combo_bcd_i
    (
        .clk    (clk),
        .reset  (reset),
        .start  (conv_start),
        .value  (combo_value),
        .digits (combo_digits),
        .done   (combo_done)
    );

    // position 0 is the most significant digit of the section.
    assign last_pos  = combo_section ? 3'd2 : 3'd5;
    assign cur_digit = combo_section ? combo_digits[3'd2 - pos] : score_digits[3'd5 - pos];
    assign glyph_addr = 7'(cur_digit) * 7'(`HUD_GLYPH_ROWS) + 7'(row);

    assign origin    = combo_section ? 22'(`HUD_COMBO_ORIGIN) : 22'(`HUD_SCORE_ORIGIN);
    assign word_addr = base_addr + origin + 22'(row) * 22'(`HUD_LINE_WORDS) + 22'(pos);
    assign final_word = (row == ROW_W'(`HUD_GLYPH_ROWS - 1)) && (pos == last_pos)
                        && (combo_section || !combo_nonzero);

    assign spend = (state == PUSH) && (credit_count != '0);
    assign credit_after_return = {1'b0, credit_count} + SUM_W'(blit.credit_return);
    assign drain_complete = (credit_after_return == SUM_W'(`HUD_FIFO_DEPTH));   // fifo empty.

    // covers the draw_start cycle so a second frame event is refused.
    assign draw_busy = draw_start || ((state != IDLE) && !((state == DRAIN) && drain_complete));

    assign blit.push = push_q;
    assign blit.word = word_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state         <= IDLE;
            credit_count  <= CREDIT_W'(`HUD_FIFO_DEPTH);
            push_q        <= 1'b0;
            score_ready   <= 1'b0;
            combo_ready   <= 1'b0;
            combo_section <= 1'b0;
            pos           <= '0;
            row           <= '0;
        end
        else
        begin
            credit_count <= CREDIT_W'(credit_after_return - SUM_W'(spend));
            push_q       <= spend;
            case (state)
                IDLE:
                begin
                    if (draw_start)
                    begin
                        state         <= CONVERT;
                        score_ready   <= 1'b0;
                        combo_ready   <= 1'b0;
                        combo_section <= 1'b0;
                        pos           <= '0;
                        row           <= '0;
                    end
                end
                CONVERT:
                begin
                    if (score_done)
                        score_ready <= 1'b1;
                    if (combo_done)
                        combo_ready <= 1'b1;
                    if (score_ready && combo_ready)
                        state <= READ;
                end
                READ:
                    state <= PUSH;      // glyph row arrives next cycle.
                PUSH:
                begin
                    if (spend)
                    begin
                        state <= READ;
                        if (row == ROW_W'(`HUD_GLYPH_ROWS - 1))
                        begin
                            row <= '0;
                            if (pos == last_pos)
                            begin
                                pos <= '0;
                                if (final_word)
                                    state <= DRAIN;
                                else
                                    combo_section <= 1'b1;
                            end
                            else
                                pos <= pos + 3'd1;
                        end
                        else
                            row <= row + 1'b1;
                    end
                end
                DRAIN:
                begin
                    if (drain_complete)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (conv_start)
        begin
            base_addr     <= buf_sel ? `HUD_BUF1_BASE : `HUD_BUF0_BASE;
            combo_nonzero <= (combo_value != '0);
        end
        if (spend)
        begin
            word_q.addr <= word_addr;
            word_q.data <= glyph_data;
            word_q.last <= final_word;
        end
    end
endmodule

/* source/glyph_ram.sv */
`timescale 1ns/1ps
`include "hud_cfg.svh"

module glyph_ram
(
    input  logic         clk,
    input  logic         wr,
    input  logic [6:0]   wr_addr,
    input  logic [127:0] wr_data,
    input  logic [6:0]   rd_addr,
    output logic [127:0] rd_data
);
    localparam int DEPTH = 10 * `HUD_GLYPH_ROWS;     // digits 0 to 9.

    logic [127:0] mem [DEPTH];

    // host port.
    always_ff @(posedge clk)
    begin
        if (wr)
            mem[wr_addr] <= wr_data;
    end

    // blitter port, registered read.
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end
endmodule

/* source/hud_cfg.svh */
`ifndef HUD_CFG_SVH
`define HUD_CFG_SVH

// glyph geometry
`define HUD_GLYPH_ROWS      8
`define HUD_LINE_WORDS      40

// word offsets of the top-left digit inside one buffer
`define HUD_SCORE_ORIGIN    16324
`define HUD_COMBO_ORIGIN    3765

`define HUD_BUF0_BASE       22'h100000
`define HUD_BUF1_BASE       22'h200000

`define HUD_FIFO_DEPTH      4
`define HUD_MEM_CREDITS     2

`define HUD_TRANSPARENT     8'hFF

// totals stop here instead of wrapping.
`define HUD_SCORE_MAX       999999
`define HUD_COMBO_MAX       999

`endif

/* source/hud_draw_pkg.sv */
package hud_draw_pkg;

    // one framebuffer write as it travels from blitter to write port.
    typedef struct packed
    {
        logic [21:0]  addr;
        logic [127:0] data;     // 16 pixels, byte 0 is the leftmost.
        logic         last;     // final word of a redraw.
    } blit_word_t;

    // index 0 holds the units digit.
    typedef logic [5:0][3:0] digit_vec_t;

endpackage

/* source/hud_event_decode.sv */
`timescale 1ns/1ps
`include "hud_cfg.svh"

module hud_event_decode
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      event_valid,
    input  hud_event_pkg::hud_event_u event_word,
    input  logic                      draw_busy,
    output logic                      draw_start,
    output logic [19:0]               score_value,
    output logic [9:0]                combo_value,
    output logic                      buf_sel
);
    logic [19:0] score_total;
    logic [9:0]  combo_total;
    logic [20:0] score_sum;
    logic        is_hit;
    logic        frame_accept;

    assign is_hit = event_valid && (event_word.hit.kind == hud_event_pkg::KIND_HIT);
    assign frame_accept = event_valid && !draw_busy
                          && (event_word.frame.kind == hud_event_pkg::KIND_FRAME);
    assign score_sum = {1'b0, score_total} + 21'(event_word.hit.points);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            score_total <= '0;
            combo_total <= '0;
            buf_sel     <= 1'b0;
            draw_start  <= 1'b0;
        end
        else
        begin
            draw_start <= frame_accept;
            if (is_hit)
            begin
                if (score_sum > 21'(`HUD_SCORE_MAX))
                    score_total <= 20'(`HUD_SCORE_MAX);
                else
                    score_total <= score_sum[19:0];
                if (event_word.hit.miss)
                    combo_total <= '0;
                else if (combo_total != 10'(`HUD_COMBO_MAX))
                    combo_total <= combo_total + 10'd1;
            end
            if (frame_accept)
                buf_sel <= ~buf_sel;    // draw into the old front buffer.
        end
    end

    // totals frozen for the whole redraw.
    always_ff @(posedge clk)
    begin
        if (frame_accept)
        begin
            score_value <= score_total;
            combo_value <= combo_total;
        end
    end
endmodule

/* source/hud_event_pkg.sv */
package hud_event_pkg;

    // bit 15 of every event word.
    typedef enum logic
    {
        KIND_HIT   = 1'b0,
        KIND_FRAME = 1'b1
    } hud_kind_e;

    typedef struct packed
    {
        hud_kind_e   kind;
        logic        miss;      // breaks the combo.
        logic [3:0]  reserved;
        logic [9:0]  points;
    } hud_hit_t;

    typedef struct packed
    {
        hud_kind_e   kind;
        logic        flip;      // back buffer swap request.
        logic [13:0] reserved;
    } hud_frame_t;

    typedef union packed
    {
        hud_hit_t   hit;
        hud_frame_t frame;
    } hud_event_u;

endpackage

/* source/score_hud.sv */
`timescale 1ns/1ps

module score_hud
(
    input  logic         clk,
    input  logic         reset,
    input  logic         event_valid,
    input  logic [15:0]  event_word,
    input  logic         glyph_wr,
    input  logic [6:0]   glyph_addr,
    input  logic [127:0] glyph_data,
    input  logic         mem_credit,
    output logic         mem_wr,
    output logic [21:0]  mem_addr,
    output logic [127:0] mem_data,
    output logic [15:0]  mem_be,
    output logic         busy,
    output logic         done
);
    hud_event_pkg::hud_event_u event_typed;
    logic                      draw_start;
    logic                      draw_busy;
    logic [19:0]               score_value;
    logic [9:0]                combo_value;
    logic                      buf_sel;
    logic [6:0]                glyph_rd_addr;
    logic [127:0]              glyph_rd_data;

    assign event_typed = event_word;
    assign busy        = draw_busy;

    blit_if blit_i (.clk(clk), .reset(reset));

    hud_event_decode decode_i
    (
        .clk         (clk),
        .reset       (reset),
        .event_valid (event_valid),
        .event_word  (event_typed),
        .draw_busy   (draw_busy),
        .draw_start  (draw_start),
        .score_value (score_value),
        .combo_value (combo_value),
        .buf_sel     (buf_sel)
    );

    glyph_ram glyph_ram_i
    (
        .clk     (clk),
        .wr      (glyph_wr),
        .wr_addr (glyph_addr),
        .wr_data (glyph_data),
        .rd_addr (glyph_rd_addr),
        .rd_data (glyph_rd_data)
    );

    glyph_blitter blitter_i
    (
        .clk         (clk),
        .reset       (reset),
        .draw_start  (draw_start),
        .score_value (score_value),
        .combo_value (combo_value),
        .buf_sel     (buf_sel),
        .glyph_data  (glyph_rd_data),
        .glyph_addr  (glyph_rd_addr),
        .draw_busy   (draw_busy),
        .blit        (blit_i.sender)
    );

    fb_write_port write_port_i
    (
        .clk        (clk),
        .reset      (reset),
        .mem_credit (mem_credit),
        .blit       (blit_i.receiver),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .mem_be     (mem_be),
        .done       (done)
    );
endmodule

/* tb/score_hud_properties.sv */
`timescale 1ns/1ps
`include "hud_cfg.svh"

module score_hud_properties
(
    input logic clk,
    input logic reset,
    input logic mem_wr,
    input logic mem_credit,
    input logic done,
    input logic push,
    input logic credit_return
);
    logic [3:0] mem_credits;    // credits seen from the memory side.
    logic [3:0] link_credits;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            mem_credits  <= 4'(`HUD_MEM_CREDITS);
            link_credits <= 4'(`HUD_FIFO_DEPTH);
        end
        else
        begin
            mem_credits  <= mem_credits - 4'(mem_wr) + 4'(mem_credit);
            link_credits <= link_credits - 4'(push) + 4'(credit_return);
        end
    end

    write_has_credit: assert property (@(posedge clk) disable iff (reset)
        mem_wr |-> (mem_credits != 4'd0))
        else $error("memory write issued with no memory credit");

    push_has_credit: assert property (@(posedge clk) disable iff (reset)
        push |-> (link_credits != 4'd0))
        else $error("blit push issued with no interface credit");

    // only the final word's link credit is still out when done fires.
    done_with_write: assert property (@(posedge clk) disable iff (reset)
        done |-> (mem_wr && (link_credits == 4'(`HUD_FIFO_DEPTH - 1))))
        else $error("done pulsed away from the final memory write of a redraw");
endmodule

bind fb_write_port score_hud_properties port_props_i
(
    .clk           (clk),
    .reset         (reset),
    .mem_wr        (mem_wr),
    .mem_credit    (mem_credit),
    .done          (done),
    .push          (blit.push),
    .credit_return (blit.credit_return)
);

bind score_hud score_hud_properties top_props_i
(
    .clk           (clk),
    .reset         (reset),
    .mem_wr        (mem_wr),
    .mem_credit    (mem_credit),
    .done          (done),
    .push          (blit_i.push),
    .credit_return (blit_i.credit_return)
);

/* tb/score_hud_tb.sv */
`timescale 1ns/1ps
`include "hud_cfg.svh"

module score_hud_tb;
    localparam int ROWS            = `HUD_GLYPH_ROWS;
    localparam int MAX_WORDS       = 9 * ROWS;     // six score and three combo digits.
    localparam int FRAME_EVENTS    = 12;
    localparam int WATCHDOG_CYCLES = FRAME_EVENTS * MAX_WORDS * 20 + 5000;
    localparam int DONE_TIMEOUT    = MAX_WORDS * 40 + 200;

    logic         clk;
    logic         reset;
    logic         event_valid;
    logic [15:0]  event_word;
    logic         glyph_wr;
    logic [6:0]   glyph_addr;
    logic [127:0] glyph_data;
    logic         mem_credit;
    logic         mem_wr;
    logic [21:0]  mem_addr;
    logic [127:0] mem_data;
    logic [15:0]  mem_be;
    logic         busy;
    logic         done;

    logic [127:0]             glyph_model [10 * ROWS];
    hud_draw_pkg::blit_word_t expect_q [$];
    hud_draw_pkg::blit_word_t seen_word;
    int                       score_m;
    int                       combo_m;
    logic                     buf_m;
    logic [31:0]              stim_lfsr;
    logic [31:0]              credit_lfsr;
    logic [31:0]              delay_bits;
    logic                     slow_credits;
    int                       in_flight;
    int                       hold;
    int                       draw_writes;
    int                       queued_words;
    int                       errors;
    int                       errors_at_start;
    int                       tests_passed;
    int                       tests_failed;
    string                    test_name;

    score_hud dut_i
    (
        .clk         (clk),
        .reset       (reset),
        .event_valid (event_valid),
        .event_word  (event_word),
        .glyph_wr    (glyph_wr),
        .glyph_addr  (glyph_addr),
        .glyph_data  (glyph_data),
        .mem_credit  (mem_credit),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .mem_be      (mem_be),
        .busy        (busy),
        .done        (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32, 22, 2, 1.
    endfunction

    task automatic take_bits(inout logic [31:0] state, input int count,
                             output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            state = lfsr_step(state);
            value = {value[30:0], state[0]};
        end
    endtask

    function automatic logic [15:0] opaque_mask(input logic [127:0] data);
        logic [15:0] mask;
        for (int i = 0; i < 16; i++)
            mask[i] = (data[8*i +: 8] != `HUD_TRANSPARENT);
        return mask;
    endfunction

    task automatic report_value(input string what, input logic [127:0] expected,
                                input logic [127:0] actual);
        $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what,
                 expected, actual);
        errors++;
    endtask

    task automatic send_hit(input logic miss, input logic [9:0] points);
        hud_event_pkg::hud_event_u ev;
        ev.hit.kind     = hud_event_pkg::KIND_HIT;
        ev.hit.miss     = miss;
        ev.hit.reserved = '0;
        ev.hit.points   = points;
        event_word  = ev;
        event_valid = 1'b1;
        if (score_m + int'(points) > `HUD_SCORE_MAX)
            score_m = `HUD_SCORE_MAX;
        else
            score_m = score_m + int'(points);
        if (miss)
            combo_m = 0;
        else if (combo_m < `HUD_COMBO_MAX)
            combo_m++;
        @(negedge clk);
        event_valid = 1'b0;
    endtask

    task automatic random_hits(input int count);
        logic [31:0] bits;
        for (int i = 0; i < count; i++)
        begin
            take_bits(stim_lfsr, 10, bits);
            send_hit(1'b0, bits[9:0]);
        end
    endtask

    task automatic load_glyphs();
        logic [31:0]  bits;
        logic [127:0] row_data;
        for (int a = 0; a < 10 * ROWS; a++)
        begin
            for (int b = 0; b < 16; b++)
            begin
                take_bits(stim_lfsr, 2, bits);
                if (bits[1:0] == 2'd0)
                    row_data[8*b +: 8] = `HUD_TRANSPARENT;     // about one byte in four.
                else
                begin
                    take_bits(stim_lfsr, 8, bits);
                    row_data[8*b +: 8] = bits[7:0];
                end
            end
            glyph_wr       = 1'b1;
            glyph_addr     = 7'(a);
            glyph_data     = row_data;
            glyph_model[a] = row_data;
            @(negedge clk);
        end
        glyph_wr = 1'b0;
    endtask

    // most significant digit first, rows 0 to 7 inside each digit.
    task automatic queue_section(input int value, input int digits, input int origin,
                                 input logic ends_draw);
        hud_draw_pkg::blit_word_t w;
        logic [21:0]              base;
        int                       place;
        int                       digit;
        base  = buf_m ? `HUD_BUF1_BASE : `HUD_BUF0_BASE;
        place = 1;
        for (int i = 1; i < digits; i++)
            place = place * 10;
        for (int p = 0; p < digits; p++)
        begin
            digit = (value / place) % 10;
            place = place / 10;
            for (int r = 0; r < ROWS; r++)
            begin
                w.addr = base + 22'(origin + r * `HUD_LINE_WORDS + p);
                w.data = glyph_model[digit * ROWS + r];
                w.last = ends_draw && (p == digits - 1) && (r == ROWS - 1);
                expect_q.push_back(w);
            end
        end
    endtask

    task automatic send_frame(input logic accept);
        hud_event_pkg::hud_event_u ev;
        if (accept && busy)
            report_value("busy before frame event", 1'b0, busy);
        if (!accept && !busy)
            report_value("busy during redraw", 1'b1, busy);
        ev.frame.kind     = hud_event_pkg::KIND_FRAME;
        ev.frame.flip     = 1'b1;
        ev.frame.reserved = '0;
        event_word  = ev;
        event_valid = 1'b1;
        if (accept)
        begin
            buf_m       = ~buf_m;     // the first redraw lands in buffer 1.
            draw_writes = 0;
            queue_section(score_m, 6, `HUD_SCORE_ORIGIN, combo_m == 0);
            if (combo_m != 0)
                queue_section(combo_m, 3, `HUD_COMBO_ORIGIN, 1'b1);
            queued_words = expect_q.size();
        end
        @(negedge clk);
        event_valid = 1'b0;
    endtask

    task automatic wait_for_done(input int expected);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT)
        begin
            seen = done;
            @(negedge clk);
            cycles++;
        end
        if (!seen)
        begin
            $display("test %s: done did not arrive within %0d cycles", test_name, DONE_TIMEOUT);
            errors++;
        end
        if (draw_writes != expected)
            report_value("write count", expected, draw_writes);
        if (expect_q.size() != 0)
        begin
            $display("test %s: %0d expected writes never appeared", test_name, expect_q.size());
            errors++;
            expect_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start)
        begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    // outputs only move on the rising edge, so the falling edge sees them settled.
    always @(negedge clk)
    begin
        if (!reset && mem_wr)
        begin
            draw_writes++;
            if (expect_q.size() == 0)
            begin
                $display("test %s: unexpected memory write to address %0h", test_name, mem_addr);
                errors++;
            end
            else
            begin
                seen_word = expect_q.pop_front();
                if (mem_addr !== seen_word.addr)
                    report_value("mem_addr", seen_word.addr, mem_addr);
                if (mem_data !== seen_word.data)
                    report_value("mem_data", seen_word.data, mem_data);
                if (mem_be !== opaque_mask(seen_word.data))
                    report_value("mem_be", opaque_mask(seen_word.data), mem_be);
                if (done !== seen_word.last)
                    report_value("done", seen_word.last, done);
            end
        end
        else if (!reset && done)
        begin
            $display("test %s: done pulsed without a memory write", test_name);
            errors++;
        end
    end

    // one credit back per write, after a random hold.
    initial
    begin
        mem_credit  = 1'b0;
        credit_lfsr = 32'h5bac;
        in_flight   = 0;
        hold        = 0;
        forever
        begin
            @(negedge clk);
            mem_credit = 1'b0;
            if (!reset)
            begin
                if (mem_wr)
                    in_flight++;
                if (in_flight > `HUD_MEM_CREDITS)
                begin
                    $display("test %s: memory writes ran %0d ahead of returned credits",
                             test_name, in_flight);
                    errors++;
                end
                if (in_flight > 0 && hold > 0)
                    hold--;
                else if (in_flight > 0)
                begin
                    mem_credit = 1'b1;
                    in_flight--;
                    if (slow_credits)
                    begin
                        take_bits(credit_lfsr, 4, delay_bits);
                        hold = int'(delay_bits);
                        take_bits(credit_lfsr, 3, delay_bits);
                        if (delay_bits == 0)
                            hold = hold + 40;     // long stall.
                    end
                    else
                    begin
                        take_bits(credit_lfsr, 2, delay_bits);
                        hold = int'(delay_bits);
                    end
                end
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        reset           = 1'b1;
        event_valid     = 1'b0;
        event_word      = '0;
        glyph_wr        = 1'b0;
        glyph_addr      = '0;
        glyph_data      = '0;
        stim_lfsr       = 32'h5bac;
        slow_credits    = 1'b0;
        score_m         = 0;
        combo_m         = 0;
        buf_m           = 1'b0;
        draw_writes     = 0;
        queued_words    = 0;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        test_name       = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test("glyph_and_score");
        load_glyphs();
        random_hits(8);
        send_frame(1'b1);
        wait_for_done(queued_words);
        finish_test();

        start_test("combo_rules");
        random_hits(5);
        send_hit(1'b1, 10'd7);
        send_frame(1'b1);
        wait_for_done(48);
        random_hits(3);
        send_frame(1'b1);
        wait_for_done(72);
        finish_test();

        start_test("transparency");
        load_glyphs();
        random_hits(4);
        send_frame(1'b1);
        wait_for_done(queued_words);
        finish_test();

        start_test("buffer_flip");
        repeat (4)
        begin
            random_hits(2);
            send_frame(1'b1);
            wait_for_done(queued_words);
        end
        finish_test();

        start_test("back_pressure");
        slow_credits = 1'b1;
        repeat (2)
        begin
            random_hits(3);
            send_frame(1'b1);
            wait_for_done(queued_words);
        end
        slow_credits = 1'b0;
        finish_test();

        start_test("saturation_and_ignored_frame");
        repeat (1000) send_hit(1'b0, 10'h3ff);
        send_frame(1'b1);
        send_frame(1'b0);
        wait_for_done(queued_words);
        repeat (50) @(negedge clk);
        send_frame(1'b1);
        wait_for_done(queued_words);
        finish_test();

        $display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
                 errors);
        if (tests_failed == 0 && errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end
endmodule
